// ==== dcache.f ====
+incdir+tb
design/dcache_pkg.sv
design/cache_way_if.sv
design/dcache_way.sv
design/dcache_ctrl.sv
design/dcache_top.sv
tb/dcache_tb.sv

// ==== tb/dcache_ref.svh ====
`ifndef DCACHE_REF_SVH
`define DCACHE_REF_SVH

// expected memory transfers, packed as {write, address, data}
logic [64:0] exp_xfer [$];

// reference memory and shadow of the cache frames
dcache_pkg::word_t ref_mem  [MEM_WORDS];
dcache_pkg::tag_t  sh_tag   [dcache_pkg::SETS][2];
bit                sh_valid [dcache_pkg::SETS][2];
bit                sh_dirty [dcache_pkg::SETS][2];
bit                sh_lru   [dcache_pkg::SETS];

// scrambled from the full byte address
function automatic dcache_pkg::word_t init_word(input int unsigned widx);
    dcache_pkg::word_t a;
    a = widx << 2;
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
endfunction

function automatic void expect_transfer(input bit is_write, input dcache_pkg::word_t addr);
    exp_xfer.push_back({is_write, addr, ref_mem[addr[9:2]]});
endfunction

function automatic void reset_shadow();
    for (int i = 0; i < MEM_WORDS; i++) begin
        ref_mem[i] = init_word(i);
    end
    for (int s = 0; s < dcache_pkg::SETS; s++) begin
        sh_lru[s] = 1'b0;
        for (int w = 0; w < 2; w++) begin
            sh_tag[s][w]   = '0;
            sh_valid[s][w] = 1'b0;
            sh_dirty[s][w] = 1'b0;
        end
    end
    exp_xfer.delete();
endfunction

// returns the word a load sees, queues the traffic a miss causes
function automatic dcache_pkg::word_t predict_access(input dcache_pkg::word_t addr,
                                                     input bit is_write,
                                                     input dcache_pkg::word_t data);
    dcache_pkg::tag_t  tag;
    dcache_pkg::idx_t  idx;
    dcache_pkg::word_t blk;
    dcache_pkg::word_t load;
    int                way;
    tag = addr[31:dcache_pkg::TAG_LSB];
    idx = addr[dcache_pkg::TAG_LSB-1:dcache_pkg::IDX_LSB];
    way = -1;
    for (int w = 0; w < 2; w++) begin
        if (sh_valid[idx][w] && (sh_tag[idx][w] == tag)) begin
            way = w;
        end
    end
    if (way < 0) begin
        // invalid way first, else the least recently used one
        if (!sh_valid[idx][0]) begin
            way = 0;
        end else if (!sh_valid[idx][1]) begin
            way = 1;
        end else begin
            way = sh_lru[idx];
        end
        if (sh_dirty[idx][way]) begin
            blk = {sh_tag[idx][way], idx, 3'b000};
            expect_transfer(1'b1, blk);
            expect_transfer(1'b1, blk | 32'h4);
        end
        blk = {tag, idx, 3'b000};
        expect_transfer(1'b0, blk);
        expect_transfer(1'b0, blk | 32'h4);
        sh_tag[idx][way]   = tag;
        sh_valid[idx][way] = 1'b1;
        sh_dirty[idx][way] = 1'b0;
    end
    sh_lru[idx] = (way == 0);
    load = ref_mem[addr[9:2]];
    if (is_write) begin
        ref_mem[addr[9:2]] = data;
        sh_dirty[idx][way] = 1'b1;
    end
    return load;
endfunction

// flush order is set 0 to 7, way 0 before way 1
function automatic int predict_flush();
    dcache_pkg::word_t blk;
    int                n;
    n = 0;
    for (int s = 0; s < dcache_pkg::SETS; s++) begin
        for (int w = 0; w < 2; w++) begin
            if (sh_valid[s][w] && sh_dirty[s][w]) begin
                blk = {sh_tag[s][w], dcache_pkg::idx_t'(s), 3'b000};
                expect_transfer(1'b1, blk);
                expect_transfer(1'b1, blk | 32'h4);
                n++;
            end
            sh_valid[s][w] = 1'b0;
            sh_dirty[s][w] = 1'b0;
        end
    end
    return n;
endfunction

`endif

// ==== tb/dcache_tb.sv ====
`timescale 1ns/100ps

module dcache_tb;

    localparam int MEM_WORDS  = 256;
    localparam int N_REQUESTS = 320;
    localparam int WORST_MISS = 4 * 4 + 2;
    // twice the worst case over all requests and flushed frames
    localparam int WATCHDOG_NS = (N_REQUESTS + 2 * dcache_pkg::SETS) * WORST_MISS * 20 * 2;

    logic              CLK;
    logic              nRST;
    logic              dmem_ren;
    logic              dmem_wen;
    logic              halt;
    dcache_pkg::word_t dmem_addr;
    dcache_pkg::word_t dmem_store;
    logic              dhit;
    logic              flushed;
    dcache_pkg::word_t dmem_load;
    logic              mem_ren;
    logic              mem_wen;
    logic              mem_wait;
    dcache_pkg::word_t mem_addr;
    dcache_pkg::word_t mem_store;
    dcache_pkg::word_t mem_load;

    // memory model
    dcache_pkg::word_t mem [MEM_WORDS];
    integer            seed;
    int                stall_left;
    logic [64:0]       xfer;

    dcache_pkg::word_t exp_load;
    int                err_count;
    int                wr_count;
    int                tests_run;
    int                tests_passed;

    `include "dcache_ref.svh"

    dcache_top dut_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .dmem_ren   (dmem_ren),
        .dmem_wen   (dmem_wen),
        .halt       (halt),
        .dmem_addr  (dmem_addr),
        .dmem_store (dmem_store),
        .dhit       (dhit),
        .flushed    (flushed),
        .dmem_load  (dmem_load),
        .mem_ren    (mem_ren),
        .mem_wen    (mem_wen),
        .mem_wait   (mem_wait),
        .mem_addr   (mem_addr),
        .mem_store  (mem_store),
        .mem_load   (mem_load)
    );

    always #10 CLK = ~CLK;

    assign mem_load = mem[mem_addr[9:2]];

    task automatic check_value(input dcache_pkg::word_t got, input dcache_pkg::word_t exp,
                               input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    // wait stretch for the next transfer
    always @(posedge CLK) begin
        #1;
        mem_wait = (stall_left != 0);
    end

    // every DUT output has settled by mid-cycle
    always @(negedge CLK) begin
        if (nRST) begin
            if (!(dmem_ren || dmem_wen)) begin
                check_value(dhit, 1'b0, "dhit with no request");
            end
            if (halt) begin
                check_value(dhit, 1'b0, "dhit during flush");
            end else begin
                check_value(flushed, 1'b0, "flushed before halt");
            end
            if (dhit && dmem_ren) begin
                check_value(dmem_load, exp_load, $sformatf("load from %h", dmem_addr));
            end
            if ((mem_ren || mem_wen) && !mem_wait) begin
                if (mem_wen) begin
                    mem[mem_addr[9:2]] = mem_store;
                    wr_count++;
                end
                if (exp_xfer.size() == 0) begin
                    $display("%0t ns: memory transfer at %h that the model did not expect",
                             $time, mem_addr);
                    err_count++;
                end else begin
                    xfer = exp_xfer.pop_front();
                    check_value(mem_wen, xfer[64], "memory write enable");
                    check_value(mem_ren, !xfer[64], "memory read enable");
                    check_value(mem_addr, xfer[63:32], "memory address");
                    if (mem_wen) begin
                        check_value(mem_store, xfer[31:0], $sformatf("write data at %h", mem_addr));
                    end
                end
                stall_left = $unsigned($random(seed)) % 4;
            end else if ((mem_ren || mem_wen) && (stall_left > 0)) begin
                stall_left--;
            end
        end
    end

    // called and returns just after a rising edge
    task automatic cpu_access(input dcache_pkg::word_t addr, input bit is_write,
                              input dcache_pkg::word_t data);
        exp_load   = predict_access(addr, is_write, data);
        dmem_addr  = addr;
        dmem_store = data;
        dmem_ren   = !is_write;
        dmem_wen   = is_write;
        @(negedge CLK);
        while (!dhit) begin
            @(negedge CLK);
        end
        @(posedge CLK);
        #1;
        dmem_ren = 1'b0;
        dmem_wen = 1'b0;
    endtask

    task automatic report_test(input string name, input int errs_before);
        check_value(exp_xfer.size(), 0, "pending memory transfers");
        tests_run++;
        if (err_count == errs_before) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            $display("test %s: fail", name);
        end
    endtask

    initial begin
        int                errs;
        int                wr_before;
        int                dirty_blocks;
        dcache_pkg::word_t addr;
        bit                is_wr;
        seed         = 32'h24f2bbde;
        CLK          = 1'b0;
        nRST         = 1'b0;
        dmem_ren     = 1'b0;
        dmem_wen     = 1'b0;
        halt         = 1'b0;
        dmem_addr    = '0;
        dmem_store   = '0;
        mem_wait     = 1'b0;
        stall_left   = 0;
        exp_load     = '0;
        err_count    = 0;
        wr_count     = 0;
        tests_run    = 0;
        tests_passed = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = init_word(i);
        end
        reset_shadow();
        repeat (4) @(posedge CLK);
        #1;
        nRST = 1'b1;
        @(posedge CLK);
        #1;

        errs = err_count;
        cpu_access(32'h000, 1'b0, '0);
        cpu_access(32'h004, 1'b0, '0);
        cpu_access(32'h008, 1'b0, '0);
        cpu_access(32'h104, 1'b0, '0);
        report_test("reset loads", errs);

        errs      = err_count;
        wr_before = wr_count;
        cpu_access(32'h010, 1'b1, 32'hcafe_f00d);
        cpu_access(32'h010, 1'b0, '0);
        cpu_access(32'h014, 1'b1, 32'h0bad_beef);
        cpu_access(32'h014, 1'b0, '0);
        check_value(wr_count - wr_before, 0, "memory writes while resident");
        report_test("store then load", errs);

        // tags 1, 2 and 3 in set 5; the dirty tag 2 block is the LRU one
        errs      = err_count;
        wr_before = wr_count;
        cpu_access(32'h068, 1'b0, '0);
        cpu_access(32'h0a8, 1'b1, 32'h1234_5678);
        cpu_access(32'h06c, 1'b0, '0);
        cpu_access(32'h0e8, 1'b0, '0);
        cpu_access(32'h068, 1'b0, '0);
        check_value(wr_count - wr_before, 2, "write-back words");
        report_test("lru eviction", errs);

        errs = err_count;
        for (int n = 0; n < 300; n++) begin
            addr  = $random(seed) & 32'h0000_01fc;
            is_wr = $random(seed) & 1;
            cpu_access(addr, is_wr, $random(seed));
        end
        report_test("random traffic", errs);

        errs         = err_count;
        dirty_blocks = predict_flush();
        wr_before    = wr_count;
        halt         = 1'b1;
        @(negedge CLK);
        while (!flushed) begin
            @(negedge CLK);
        end
        repeat (4) begin
            @(negedge CLK);
            check_value(flushed, 1'b1, "flushed");
        end
        check_value(wr_count - wr_before, 2 * dirty_blocks, "flush write words");
        for (int i = 0; i < MEM_WORDS; i++) begin
            check_value(mem[i], ref_mem[i], $sformatf("memory word %h", i * 4));
        end
        report_test("halt flush", errs);

        $display("tests passed %0d of %0d, errors %0d", tests_passed, tests_run, err_count);
        if (err_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== design/dcache_top.sv ====
`timescale 1ns/100ps

module dcache_top (
    input  logic              CLK,
    input  logic              nRST,
    // processor side
    input  logic              dmem_ren,
    input  logic              dmem_wen,
    input  logic              halt,
    input  dcache_pkg::word_t dmem_addr,
    input  dcache_pkg::word_t dmem_store,
    output logic              dhit,
    output logic              flushed,
    output dcache_pkg::word_t dmem_load,
    // memory side
    output logic              mem_ren,
    output logic              mem_wen,
    input  logic              mem_wait,
    output dcache_pkg::word_t mem_addr,
    output dcache_pkg::word_t mem_store,
    input  dcache_pkg::word_t mem_load
);

    cache_way_if way0_bus ();
    cache_way_if way1_bus ();

    // two ways side by side
    dcache_way way0_i (
        .CLK  (CLK),
        .nRST (nRST),
        .port (way0_bus)
    );

    dcache_way way1_i (
        .CLK  (CLK),
        .nRST (nRST),
        .port (way1_bus)
    );

    dcache_ctrl ctrl_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .way0       (way0_bus),
        .way1       (way1_bus),
        .dmem_ren   (dmem_ren),
        .dmem_wen   (dmem_wen),
        .halt       (halt),
        .dmem_addr  (dmem_addr),
        .dmem_store (dmem_store),
        .dhit       (dhit),
        .flushed    (flushed),
        .dmem_load  (dmem_load),
        .mem_ren    (mem_ren),
        .mem_wen    (mem_wen),
        .mem_wait   (mem_wait),
        .mem_addr   (mem_addr),
        .mem_store  (mem_store),
        .mem_load   (mem_load)
    );

endmodule

// ==== design/dcache_ctrl.sv ====
`timescale 1ns/100ps

module dcache_ctrl (
    input  logic              CLK,
    input  logic              nRST,
    cache_way_if.ctrl         way0,
    cache_way_if.ctrl         way1,
    input  logic              dmem_ren,
    input  logic              dmem_wen,
    input  logic              halt,
    input  dcache_pkg::word_t dmem_addr,
    input  dcache_pkg::word_t dmem_store,
    output logic              dhit,
    output logic              flushed,
    output dcache_pkg::word_t dmem_load,
    output logic              mem_ren,
    output logic              mem_wen,
    input  logic              mem_wait,
    output dcache_pkg::word_t mem_addr,
    output dcache_pkg::word_t mem_store,
    input  dcache_pkg::word_t mem_load
);

    dcache_pkg::dcache_state_e state_q;
    dcache_pkg::dcache_state_e next_state;

    // request address fields, held stable by the processor during a miss
    dcache_pkg::tag_t req_tag;
    dcache_pkg::idx_t req_idx;
    logic             req_off;
    logic             req;

    // replacement bits name the least recently used way
    logic [dcache_pkg::SETS-1:0] lru_q;
    logic [dcache_pkg::SETS-1:0] next_lru;

    // victim way on a miss, current way during the flush walk
    logic             way_sel_q;
    logic             next_way_sel;
    dcache_pkg::idx_t flush_idx_q;
    dcache_pkg::idx_t next_flush_idx;

    logic              in_flush;
    dcache_pkg::idx_t  look_idx;
    logic              victim;
    logic              cur_way;
    logic              cur_dirty;
    dcache_pkg::tag_t  cur_tag;
    dcache_pkg::word_t cur_data0;
    dcache_pkg::word_t cur_data1;
    logic              last_frame;
    logic              flush_step;
    logic              mem_off;
    dcache_pkg::tag_t  mem_tag;

    // way update controls before the way select
    logic              tgt_way;
    logic              wr_word;
    logic              wr_sel;
    dcache_pkg::word_t wr_data;
    logic              set_dirty;
    logic              fill_tag;
    logic              set_valid;
    logic              clear;

    assign req_tag = dmem_addr[31:dcache_pkg::TAG_LSB];
    assign req_idx = dmem_addr[dcache_pkg::TAG_LSB-1:dcache_pkg::IDX_LSB];
    assign req_off = dmem_addr[dcache_pkg::BLKOFF_BIT];
    assign req     = dmem_ren || dmem_wen;

    assign in_flush = (state_q == dcache_pkg::FLUSH_SCAN) ||
                      (state_q == dcache_pkg::FLUSH_WB1) ||
                      (state_q == dcache_pkg::FLUSH_WB2) ||
                      (state_q == dcache_pkg::FLUSHED);
    assign look_idx = in_flush ? flush_idx_q : req_idx;

    // invalid way first, way 0 before way 1, else the LRU way
    always_comb begin
        if (!way0.valid) begin
            victim = 1'b0;
        end else if (!way1.valid) begin
            victim = 1'b1;
        end else begin
            victim = lru_q[req_idx];
        end
    end

    // frame the memory traffic works on
    assign cur_way   = (state_q == dcache_pkg::IDLE) ? victim : way_sel_q;
    assign cur_dirty = cur_way ? way1.dirty      : way0.dirty;
    assign cur_tag   = cur_way ? way1.stored_tag : way0.stored_tag;
    assign cur_data0 = cur_way ? way1.data0      : way0.data0;
    assign cur_data1 = cur_way ? way1.data1      : way0.data1;

    assign last_frame = (flush_idx_q == dcache_pkg::idx_t'(dcache_pkg::SETS - 1)) && way_sel_q;

    // processor load mux
    always_comb begin
        if (way1.hit) begin
            dmem_load = req_off ? way1.data1 : way1.data0;
        end else begin
            dmem_load = req_off ? way0.data1 : way0.data0;
        end
    end

    // fills use the request tag, write-backs the stored one
    assign mem_tag = ((state_q == dcache_pkg::FILL1) || (state_q == dcache_pkg::FILL2)) ?
                     req_tag : cur_tag;
    assign mem_addr  = {mem_tag, look_idx, mem_off, 2'b00};
    assign mem_store = mem_off ? cur_data1 : cur_data0;
    assign flushed   = (state_q == dcache_pkg::FLUSHED);

    always_comb begin
        next_state     = state_q;
        next_lru       = lru_q;
        next_way_sel   = way_sel_q;
        next_flush_idx = flush_idx_q;
        dhit           = 1'b0;
        mem_ren        = 1'b0;
        mem_wen        = 1'b0;
        mem_off        = 1'b0;
        tgt_way        = way_sel_q;
        wr_word        = 1'b0;
        wr_sel         = req_off;
        wr_data        = dmem_store;
        set_dirty      = 1'b0;
        fill_tag       = 1'b0;
        set_valid      = 1'b0;
        clear          = 1'b0;
        flush_step     = 1'b0;

        case (state_q)
            dcache_pkg::IDLE: begin
                if (halt) begin
                    next_state     = dcache_pkg::FLUSH_SCAN;
                    next_way_sel   = 1'b0;
                    next_flush_idx = '0;
                end else if (req && (way0.hit || way1.hit)) begin
                    dhit              = 1'b1;
                    tgt_way           = way1.hit;
                    next_lru[req_idx] = ~way1.hit;
                    if (dmem_wen) begin
                        wr_word   = 1'b1;
                        set_dirty = 1'b1;
                    end
                end else if (req) begin
                    next_way_sel = victim;
                    next_state   = cur_dirty ? dcache_pkg::WB1 : dcache_pkg::FILL1;
                end
            end
            dcache_pkg::WB1: begin
                mem_wen = 1'b1;
                if (!mem_wait) begin
                    next_state = dcache_pkg::WB2;
                end
            end
            dcache_pkg::WB2: begin
                mem_wen = 1'b1;
                mem_off = 1'b1;
                if (!mem_wait) begin
                    next_state = dcache_pkg::FILL1;
                end
            end
            dcache_pkg::FILL1: begin
                mem_ren = 1'b1;
                if (!mem_wait) begin
                    // first word also brings the new tag
                    wr_word    = 1'b1;
                    wr_sel     = 1'b0;
                    wr_data    = mem_load;
                    fill_tag   = 1'b1;
                    next_state = dcache_pkg::FILL2;
                end
            end
            dcache_pkg::FILL2: begin
                mem_ren = 1'b1;
                mem_off = 1'b1;
                if (!mem_wait) begin
                    wr_word           = 1'b1;
                    wr_sel            = 1'b1;
                    wr_data           = mem_load;
                    set_valid         = 1'b1;
                    next_lru[req_idx] = ~way_sel_q;
                    next_state        = dcache_pkg::IDLE;
                end
            end
            dcache_pkg::FLUSH_SCAN: begin
                if (cur_dirty) begin
                    next_state = dcache_pkg::FLUSH_WB1;
                end else begin
                    clear      = 1'b1;
                    flush_step = 1'b1;
                end
            end
            dcache_pkg::FLUSH_WB1: begin
                mem_wen = 1'b1;
                if (!mem_wait) begin
                    next_state = dcache_pkg::FLUSH_WB2;
                end
            end
            dcache_pkg::FLUSH_WB2: begin
                mem_wen = 1'b1;
                mem_off = 1'b1;
                if (!mem_wait) begin
                    clear      = 1'b1;
                    flush_step = 1'b1;
                end
            end
            default: begin
                // FLUSHED holds until reset
                next_state = state_q;
            end
        endcase

        // walk way 0 then way 1 of each set
        if (flush_step) begin
            if (last_frame) begin
                next_state = dcache_pkg::FLUSHED;
            end else begin
                next_state   = dcache_pkg::FLUSH_SCAN;
                next_way_sel = ~way_sel_q;
                if (way_sel_q) begin
                    next_flush_idx = flush_idx_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state_q     <= dcache_pkg::IDLE;
            lru_q       <= '0;
            way_sel_q   <= 1'b0;
            flush_idx_q <= '0;
        end else begin
            state_q     <= next_state;
            lru_q       <= next_lru;
            way_sel_q   <= next_way_sel;
            flush_idx_q <= next_flush_idx;
        end
    end

    // both ways look at the same set, updates go to one
    assign way0.idx         = look_idx;
    assign way0.tag         = req_tag;
    assign way0.wr_sel      = wr_sel;
    assign way0.wr_data     = wr_data;
    assign way0.wr_word     = wr_word && !tgt_way;
    assign way0.set_dirty   = set_dirty && !tgt_way;
    assign way0.fill_tag_en = fill_tag && !tgt_way;
    assign way0.set_valid   = set_valid && !tgt_way;
    assign way0.clear       = clear && !tgt_way;

    assign way1.idx         = look_idx;
    assign way1.tag         = req_tag;
    assign way1.wr_sel      = wr_sel;
    assign way1.wr_data     = wr_data;
    assign way1.wr_word     = wr_word && tgt_way;
    assign way1.set_dirty   = set_dirty && tgt_way;
    assign way1.fill_tag_en = fill_tag && tgt_way;
    assign way1.set_valid   = set_valid && tgt_way;
    assign way1.clear       = clear && tgt_way;

endmodule

// ==== design/dcache_way.sv ====
`timescale 1ns/100ps

module dcache_way (
    input logic      CLK,
    input logic      nRST,
    cache_way_if.way port
);

    // frame state, one bit per set
    logic [dcache_pkg::SETS-1:0] valid_q;
    logic [dcache_pkg::SETS-1:0] dirty_q;

    // frame payload
    dcache_pkg::tag_t  tag_q  [dcache_pkg::SETS];
    dcache_pkg::word_t data_q [dcache_pkg::SETS][dcache_pkg::BLOCK_WORDS];

    // lookup of the indexed set
    assign port.valid      = valid_q[port.idx];
    assign port.dirty      = dirty_q[port.idx];
    assign port.stored_tag = tag_q[port.idx];
    assign port.data0      = data_q[port.idx][0];
    assign port.data1      = data_q[port.idx][1];

    // hit only on a valid frame with matching tag
    assign port.hit = valid_q[port.idx] && (tag_q[port.idx] == port.tag);

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (port.clear) begin
            // flush drops the frame
            valid_q[port.idx] <= 1'b0;
            dirty_q[port.idx] <= 1'b0;
        end else begin
            if (port.set_valid) begin
                valid_q[port.idx] <= 1'b1;
            end
            // new tag means a clean block
            if (port.fill_tag_en) begin
                dirty_q[port.idx] <= 1'b0;
            end else if (port.set_dirty) begin
                dirty_q[port.idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (port.fill_tag_en) begin
            tag_q[port.idx] <= port.tag;
        end
        // one word per cycle, either from a store hit or a fill
        if (port.wr_word) begin
            data_q[port.idx][port.wr_sel] <= port.wr_data;
        end
    end

endmodule

// ==== design/cache_way_if.sv ====
`timescale 1ns/100ps

interface cache_way_if;

    // lookup request from the controller
    dcache_pkg::idx_t  idx;
    dcache_pkg::tag_t  tag;

    // update controls, applied at the next edge
    logic              wr_word;
    logic              wr_sel;
    dcache_pkg::word_t wr_data;
    logic              set_dirty;
    logic              fill_tag_en;
    logic              set_valid;
    logic              clear;

    // lookup result for the indexed set
    logic              hit;
    logic              valid;
    logic              dirty;
    dcache_pkg::tag_t  stored_tag;
    dcache_pkg::word_t data0;
    dcache_pkg::word_t data1;

    modport ctrl (
        output idx, tag, wr_word, wr_sel, wr_data, set_dirty, fill_tag_en, set_valid, clear,
        input  hit, valid, dirty, stored_tag, data0, data1
    );

    modport way (
        input  idx, tag, wr_word, wr_sel, wr_data, set_dirty, fill_tag_en, set_valid, clear,
        output hit, valid, dirty, stored_tag, data0, data1
    );

endinterface

// ==== design/dcache_pkg.sv ====
package dcache_pkg;

    // data and address words are the same width
    typedef logic [31:0] word_t;

    // address fields: tag | index | block offset | byte offset
    typedef logic [25:0] tag_t;
    typedef logic [2:0]  idx_t;

    // cache geometry
    localparam int SETS        = 8;
    localparam int BLOCK_WORDS = 2;

    // address bit positions
    localparam int TAG_LSB    = 6;
    localparam int IDX_LSB    = 3;
    localparam int BLKOFF_BIT = 2;

    // controller states
    typedef enum logic [3:0] {
        IDLE       = 4'd0,
        WB1        = 4'd1,
        WB2        = 4'd2,
        FILL1      = 4'd3,
        FILL2      = 4'd4,
        FLUSH_SCAN = 4'd5,
        FLUSH_WB1  = 4'd6,
        FLUSH_WB2  = 4'd7,
        FLUSHED    = 4'd8
    } dcache_state_e;

endpackage
